/* vlog.f */
slice_fmt_pkg.sv
slice_op_pkg.sv
lane_result_if.sv
nc_lane.sv
lane_array.sv
cpk_target_pipe.sv
result_assembler.sv
fp_slice_top.sv
fp_slice_assert.sv
tb_fp_slice.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fp_slice
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
SIMFLAGS  ?= +verilator+error+limit+100
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIMFLAGS) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_fp_slice.sv */
`timescale 1ns/1ps

module tb_fp_slice;
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  typedef struct {
    string      name;
    operation_e op;
    logic       rnd;  // MIN becomes MAX when set
    logic       mod;
    fp_format_e fmt;
    logic       vec;
    data_t      a, b, c;
    lane_mask_t mask;
    data_t      exp_result;
    status_t    exp_status;
  } test_t;

  logic       clk_i = 1'b0;
  logic       rst_i, flush_i, op_mod_i, rnd_mode_i, vectorial_op_i;
  logic       in_valid_i, in_ready_o, out_ready_i, out_valid_o, busy_o;
  data_t      operand_a_i, operand_b_i, operand_c_i, result_o;
  operation_e op_i;
  fp_format_e src_fmt_i, dst_fmt_i;
  lane_mask_t simd_mask_i;
  status_t    status_o;

  test_t       tests[$];
  logic [31:0] lfsr_state = 32'ha640;
  int unsigned result_errors = 0;
  int unsigned status_errors = 0;
  int unsigned protocol_errors = 0;

  always #5 clk_i = ~clk_i;

  fp_slice_top fp_slice_top_i (.*);

  // ----------------------------------------------------------
  // Random operands
  // ----------------------------------------------------------
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]; // x^32+x^22+x^2+x+1
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < WIDTH; i++) begin
      w[i] = lfsr_step();
    end
    return w;
  endfunction

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic is_nan(lane_data_t x, fp_format_e fmt);
    if (fmt == FP16) return (x[14:10] == 5'h1f) && (x[9:0] != '0);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  // Quiet bit is the top mantissa bit
  function automatic logic is_snan(lane_data_t x, fp_format_e fmt);
    return is_nan(x, fmt) && !((fmt == FP16) ? x[9] : x[22]);
  endfunction

  // Maps a value onto a line where -0 sits just below +0
  function automatic longint order_key(lane_data_t x, int unsigned w);
    longint mag;
    mag = longint'(x & ((lane_data_t'(1) << (w - 1)) - 1));
    if (x[w-1]) return -mag - 1;
    return mag;
  endfunction

  function automatic lane_data_t elem_result(operation_e op, fp_format_e fmt,
                                             lane_data_t a, lane_data_t b,
                                             output logic nv);
    int unsigned w;
    logic        a_below;
    lane_data_t  r;
    w  = (fmt == FP16) ? 16 : 32;
    nv = 1'b0;
    r  = a;
    case (op)
      SGNJ:  r[w-1] = b[w-1];
      SGNJN: r[w-1] = !b[w-1];
      SGNJX: r[w-1] = a[w-1] ^ b[w-1];
      MIN, MAX: begin
        nv = is_snan(a, fmt) || is_snan(b, fmt);
        a_below = order_key(a, w) < order_key(b, w);
        if (is_nan(a, fmt) && is_nan(b, fmt)) begin
          r = (fmt == FP16) ? 32'h0000_7e00 : 32'h7fc0_0000; // Canonical quiet NaN
        end else if (is_nan(a, fmt)) begin
          r = b;
        end else if (is_nan(b, fmt)) begin
          r = a;
        end else begin
          r = ((op == MIN) ? a_below : !a_below) ? a : b;
        end
      end
      default: r = a;
    endcase
    return r;
  endfunction

  function automatic test_t with_expected(test_t t);
    int unsigned w, slot;
    data_t       res, pair, wmask;
    status_t     st;
    lane_data_t  er;
    logic        nv;
    operation_e  eff;
    w     = (t.fmt == FP16) ? 16 : 32;
    wmask = (data_t'(1) << w) - 1;
    eff   = (t.op == MIN && t.rnd) ? MAX : t.op;
    st    = '0;
    if (eff == CPKAB || eff == CPKCD) begin
      slot = {eff == CPKCD, t.mod};
      pair = ((t.b & wmask) << w) | (t.a & wmask);
      res  = t.c;
      if (2 * (slot + 1) * w > WIDTH) begin
        res = '0; // Slot lies past the word
      end else begin
        for (int i = 0; i < 2 * w; i++) res[2*slot*w + i] = pair[i];
      end
    end else begin
      res = '1;
      for (int l = 0; l < (t.vec ? WIDTH / w : 1); l++) begin
        er = elem_result(eff, t.fmt, lane_data_t'(t.a >> (l * w)),
                         lane_data_t'(t.b >> (l * w)), nv);
        for (int i = 0; i < w; i++) res[l*w + i] = er[i];
        if (nv && t.mask[l]) st[STATUS_NV] = 1'b1;
      end
    end
    t.exp_result = res;
    t.exp_status = st;
    return t;
  endfunction

  task automatic add_test(string name, operation_e op, logic rnd, logic mod,
                          fp_format_e fmt, logic vec, data_t a, data_t b, data_t c,
                          lane_mask_t mask);
    test_t t;
    t = '{name, op, rnd, mod, fmt, vec, a, b, c, mask, '0, '0};
    tests.push_back(with_expected(t));
  endtask

  task automatic add_random(string name, operation_e op, logic rnd, logic mod,
                            fp_format_e fmt, logic vec, lane_mask_t mask);
    data_t a, b, c;
    a = rand_word();
    b = rand_word();
    c = rand_word();
    add_test(name, op, rnd, mod, fmt, vec, a, b, c, mask);
  endtask

  // ----------------------------------------------------------
  // Driving and checking
  // ----------------------------------------------------------
  task automatic check_result(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      result_errors++;
      $display("mismatch %s result: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_status(string name, status_t expected, status_t actual);
    if (actual !== expected) begin
      status_errors++;
      $display("mismatch %s status: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_item(int idx);
    operand_a_i    <= tests[idx].a;
    operand_b_i    <= tests[idx].b;
    operand_c_i    <= tests[idx].c;
    op_i           <= tests[idx].op;
    op_mod_i       <= tests[idx].mod;
    rnd_mode_i     <= tests[idx].rnd;
    src_fmt_i      <= tests[idx].fmt;
    dst_fmt_i      <= tests[idx].fmt;
    vectorial_op_i <= tests[idx].vec;
    simd_mask_i    <= tests[idx].mask;
    in_valid_i     <= 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic collect_item(int idx, output int waited);
    @(negedge clk_i);
    waited = 1;
    while (!(out_valid_o && out_ready_i)) begin
      @(negedge clk_i);
      waited++;
    end
    check_result(tests[idx].name, tests[idx].exp_result, result_o);
    check_status(tests[idx].name, tests[idx].exp_status, status_o);
  endtask

  task automatic check_latency(int idx, int waited);
    if (waited != NUM_PIPE_REGS) begin
      protocol_errors++;
      $display("Test %s came out %0d cycles after acceptance instead of %0d",
               tests[idx].name, waited, NUM_PIPE_REGS);
    end
  endtask

  initial begin : watchdog
    int unsigned limit;
    #1;
    limit = (tests.size() + 10) * 20;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    int          waited, n;
    int unsigned assert_errors;
    rst_i = 1'b1;
    flush_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i = SGNJ;
    op_mod_i = 1'b0;
    rnd_mode_i = 1'b0;
    src_fmt_i = FP32;
    dst_fmt_i = FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i = '0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;

    // Scalar sign-injection, upper bits must come back as ones
    add_random("sgnj_fp32", SGNJ, 0, 0, FP32, 0, 4'b0001);
    add_random("sgnjn_fp32", SGNJN, 0, 0, FP32, 0, 4'b0001);
    add_random("sgnjx_fp32", SGNJX, 0, 0, FP32, 0, 4'b0001);
    add_random("sgnj_fp16", SGNJ, 0, 0, FP16, 0, 4'b0001);
    add_random("sgnjn_fp16", SGNJN, 0, 0, FP16, 0, 4'b0001);
    add_random("sgnjx_fp16", SGNJX, 0, 0, FP16, 0, 4'b0001);
    add_random("min_fp16_vec", MIN, 0, 0, FP16, 1, 4'b1111);
    add_random("max_fp16_vec", MAX, 0, 0, FP16, 1, 4'b1011);
    add_random("min_rnd_fp16_vec", MIN, 1, 0, FP16, 1, 4'b1111);
    add_random("min_fp32_vec", MIN, 0, 0, FP32, 1, 4'b0011);
    add_random("max_fp32_vec", MAX, 0, 0, FP32, 1, 4'b0011);
    // Lanes: qNaN in B, NaN pair with sNaN, sNaN in A, -0 against +0
    add_test("nan_min_fp16", MIN, 0, 0, FP16, 1, 64'h8000_7d00_7e00_3c00,
             64'h0000_3c00_7c01_7e00, '0, 4'b1111);
    add_test("nan_min_fp16_masked", MIN, 0, 0, FP16, 1, 64'h8000_7d00_7e00_3c00,
             64'h0000_3c00_7c01_7e00, '0, 4'b1001);
    add_test("nan_max_fp16_lane2", MAX, 0, 0, FP16, 1, 64'h8000_7d00_7e00_3c00,
             64'h0000_3c00_7c01_7e00, '0, 4'b0100);
    add_test("nan_min_fp32", MIN, 0, 0, FP32, 1, 64'h7fa0_0000_8000_0000,
             64'h3f80_0000_0000_0000, '0, 4'b0011);
    add_test("nan_min_fp32_masked", MIN, 0, 0, FP32, 1, 64'h7fa0_0000_8000_0000,
             64'h3f80_0000_0000_0000, '0, 4'b0001);
    add_test("nan_max_fp32", MIN, 1, 0, FP32, 1, 64'h7fa0_0000_8000_0000,
             64'h3f80_0000_0000_0000, '0, 4'b0010);
    add_random("cpkcd0_fp16", CPKCD, 0, 0, FP16, 1, 4'b1111);
    add_random("cpkcd1_fp16", CPKCD, 0, 1, FP16, 1, 4'b1111);
    add_random("cpkab1_fp32", CPKAB, 0, 1, FP32, 1, 4'b1111);
    add_random("cpkcd0_fp32", CPKCD, 0, 0, FP32, 1, 4'b1111);
    add_random("cpkcd1_fp32", CPKCD, 0, 1, FP32, 1, 4'b1111);
    add_random("cpkab0_fp16", CPKAB, 0, 0, FP16, 1, 4'b1111);
    add_random("cpkab1_fp16", CPKAB, 0, 1, FP16, 1, 4'b1111);
    add_random("cpkab0_fp32", CPKAB, 0, 0, FP32, 1, 4'b1111);
    n = tests.size();

    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      send_item(i);
      collect_item(i, waited);
      check_latency(i, waited);
    end

    // ----------------------------------------------------------
    // Back-pressure, then flush
    // ----------------------------------------------------------
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send_item(n - 2);
    send_item(n - 1);
    repeat (3) begin
      @(negedge clk_i);
      if (in_ready_o) begin
        protocol_errors++;
        $display("in_ready_o stayed high while the pipeline was full");
      end
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    collect_item(n - 2, waited);
    collect_item(n - 1, waited);

    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send_item(n - 3);
    send_item(n - 4);
    @(negedge clk_i);
    if (!busy_o) begin
      protocol_errors++;
      $display("busy_o was low with two items in flight");
    end
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i     <= 1'b0;
    out_ready_i <= 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      if (out_valid_o) begin
        protocol_errors++;
        $display("An item from before the flush reached the output");
      end
    end
    if (busy_o) begin
      protocol_errors++;
      $display("busy_o stayed high after the flush");
    end
    @(posedge clk_i);
    send_item(n - 1); // Pipeline still works after a flush
    collect_item(n - 1, waited);
    check_latency(n - 1, waited);

    @(posedge clk_i);
    assert_errors = fp_slice_top_i.fp_slice_assert_i.failures;
    $display("Errors: result %0d, status %0d, protocol %0d, assertion %0d",
             result_errors, status_errors, protocol_errors, assert_errors);
    if (result_errors + status_errors + protocol_errors + assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* fp_slice_assert.sv */
`timescale 1ns/1ps

module fp_slice_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 flush_i,
  input logic                 in_valid_i,
  input logic                 in_ready_o,
  input logic                 out_ready_i,
  input logic                 out_valid_o,
  input logic                 busy_o,
  input slice_fmt_pkg::data_t result_o
);
  import slice_op_pkg::*;

  int unsigned failures = 0;
  int unsigned in_flight; // Accepted by lane 0 and not yet delivered

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + 32'(in_valid_i && in_ready_o) - 32'(out_valid_o && out_ready_i);
    end
  end

  reset_clears: assert property (@(posedge clk_i) rst_i |=> !out_valid_o && !busy_o)
    else begin
      failures++;
      $error("Output valid or busy high after reset");
    end

  // Held results must not move until the consumer takes them
  hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o))
    else begin
      failures++;
      $error("Result changed while stalled");
    end

  full_blocks_input: assert property (@(posedge clk_i) disable iff (rst_i)
      (in_flight >= NUM_PIPE_REGS) && !out_ready_i |-> !in_ready_o)
    else begin
      failures++;
      $error("Input ready high with a full pipeline");
    end

endmodule

bind fp_slice_top fp_slice_assert fp_slice_assert_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .out_ready_i (out_ready_i),
  .out_valid_o (out_valid_o),
  .busy_o      (busy_o),
  .result_o    (result_o)
);

/* fp_slice_top.sv */
`timescale 1ns/1ps

module fp_slice_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  slice_fmt_pkg::data_t      operand_a_i,
  input  slice_fmt_pkg::data_t      operand_b_i,
  input  slice_fmt_pkg::data_t      operand_c_i,
  input  slice_op_pkg::operation_e  op_i,
  input  logic                      op_mod_i,
  input  logic                      rnd_mode_i,
  input  slice_fmt_pkg::fp_format_e src_fmt_i,
  input  slice_fmt_pkg::fp_format_e dst_fmt_i,
  input  logic                      vectorial_op_i,
  input  slice_fmt_pkg::lane_mask_t simd_mask_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      out_ready_i,
  output slice_fmt_pkg::data_t      result_o,
  output slice_op_pkg::status_t     status_o,
  output logic                      out_valid_o,
  output logic                      busy_o
);
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  data_t      operands[NUM_OPERANDS];
  operation_e lane_op;
  logic       is_cpk, byp_in_valid, byp_out_ready;
  vec_op_t    vec_op, target_vec_op;
  aux_t       aux;
  data_t      target_q;

  lane_result_if lane_if ();

  assign operands = '{operand_a_i, operand_b_i, operand_c_i};

  // ----------------------------------------------------------
  // Input decode
  // ----------------------------------------------------------
  always_comb begin : fold_rnd_mode
    lane_op = op_i;
    if ((op_i == MIN) && rnd_mode_i) begin
      lane_op = MAX;
    end
  end

  assign is_cpk = (op_i == CPKAB) || (op_i == CPKCD);
  assign vec_op = {op_i == CPKCD, op_mod_i}; // Pack slot 0..3
  assign aux    = {is_cpk, vectorial_op_i, dst_fmt_i};

  // Bypass only takes what lane 0 takes, so both stay in step
  assign byp_in_valid  = in_valid_i & vectorial_op_i & in_ready_o;
  assign byp_out_ready = out_ready_i & lane_if.aux[AUX_VEC_BIT];

  lane_array lane_array_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .operand_a_i    (operands[0]),
    .operand_b_i    (operands[1]),
    .op_i           (lane_op),
    .src_fmt_i      (src_fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .aux_i          (aux),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .busy_o         (busy_o),
    .result_if      (lane_if)
  );

  cpk_target_pipe cpk_target_pipe_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .target_i    (operands[2]),
    .vec_op_i    (vec_op),
    .in_valid_i  (byp_in_valid),
    .out_ready_i (byp_out_ready),
    .target_o    (target_q),
    .vec_op_o    (target_vec_op)
  );

  result_assembler result_assembler_i (
    .result_if   (lane_if),
    .out_ready_i (out_ready_i),
    .target_i    (target_q),
    .vec_op_i    (target_vec_op),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o)
  );

endmodule

/* result_assembler.sv */
`timescale 1ns/1ps

module result_assembler (
  lane_result_if.consumer         result_if,
  input  logic                    out_ready_i,
  input  slice_fmt_pkg::data_t    target_i,
  input  slice_op_pkg::vec_op_t   vec_op_i,
  output slice_fmt_pkg::data_t    result_o,
  output slice_op_pkg::status_t   status_o,
  output logic                    out_valid_o
);
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  data_t      fmt_result[NUM_FORMATS];
  data_t      cpk_result[NUM_FORMATS][NUM_CPK_SLOTS];
  fp_format_e res_fmt;
  logic       res_cpk;

  assign res_fmt = fp_format_e'(result_if.aux[AUX_FMT_BIT]);
  assign res_cpk = result_if.aux[AUX_CPK_BIT];

  // ----------------------------------------------------------
  // Per-format packing
  // ----------------------------------------------------------
  for (genvar fmt = 0; fmt < NUM_FORMATS; fmt++) begin : gen_fmt
    localparam int unsigned FPW = fp_width(fp_format_e'(fmt));

    // Idle lanes stay all ones, which NaN-boxes scalar results
    always_comb begin : pack_lanes
      fmt_result[fmt] = '1;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (result_if.lane_valid[l] && ((l + 1) * FPW <= WIDTH)) begin
          fmt_result[fmt][l*FPW +: FPW] = result_if.lane_result[l][FPW-1:0];
        end
      end
    end

    for (genvar s = 0; s < NUM_CPK_SLOTS; s++) begin : gen_slot
      if (2 * (s + 1) * FPW <= WIDTH) begin : fits
        always_comb begin : pack_cpk
          cpk_result[fmt][s] = target_i; // Operand C pre-load
          cpk_result[fmt][s][2*s*FPW +: 2*FPW] = fmt_result[fmt][2*FPW-1:0];
        end
      end else begin : no_fit
        assign cpk_result[fmt][s] = '0;
      end
    end
  end

  assign result_o = res_cpk ? cpk_result[res_fmt][vec_op_i] : fmt_result[res_fmt];

  // Lanes past the format's lane count never flag
  always_comb begin : collapse_status
    status_t acc;
    acc = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (result_if.lane_valid[l] && (l * fp_width(res_fmt) < WIDTH)) begin
        acc |= result_if.lane_status[l] & {$bits(status_t){result_if.lane_mask[l]}};
      end
    end
    status_o = acc;
  end

  assign out_valid_o         = result_if.lane_valid[0];
  assign result_if.out_ready = out_ready_i;

endmodule

/* cpk_target_pipe.sv */
`timescale 1ns/1ps

module cpk_target_pipe (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  slice_fmt_pkg::data_t   target_i,
  input  slice_op_pkg::vec_op_t  vec_op_i,
  input  logic                   in_valid_i,
  input  logic                   out_ready_i,
  output slice_fmt_pkg::data_t   target_o,
  output slice_op_pkg::vec_op_t  vec_op_o
);
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  // Index i holds the item after i register stages
  data_t   target_q[NUM_PIPE_REGS+1];
  vec_op_t vec_op_q[NUM_PIPE_REGS+1];
  logic    valid_q [NUM_PIPE_REGS+1];
  logic [1:NUM_PIPE_REGS+1] ready;

  assign target_q[0] = target_i;
  assign vec_op_q[0] = vec_op_i;
  assign valid_q[0]  = in_valid_i;
  assign ready[NUM_PIPE_REGS+1] = out_ready_i;

  for (genvar i = 1; i <= NUM_PIPE_REGS; i++) begin : gen_stage
    assign ready[i] = ready[i+1] | ~valid_q[i];

    always_ff @(posedge clk_i) begin : stage_valid
      if (rst_i || flush_i) begin
        valid_q[i] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i] <= valid_q[i-1];
      end
    end

    always_ff @(posedge clk_i) begin : stage_data
      if (ready[i] && valid_q[i-1]) begin
        target_q[i] <= target_q[i-1];
        vec_op_q[i] <= vec_op_q[i-1];
      end
    end
  end

  assign target_o = target_q[NUM_PIPE_REGS]; // Lines up with lane outputs
  assign vec_op_o = vec_op_q[NUM_PIPE_REGS];

endmodule

/* lane_array.sv */
`timescale 1ns/1ps

module lane_array (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  slice_fmt_pkg::data_t      operand_a_i,
  input  slice_fmt_pkg::data_t      operand_b_i,
  input  slice_op_pkg::operation_e  op_i,
  input  slice_fmt_pkg::fp_format_e src_fmt_i,
  input  logic                      vectorial_op_i,
  input  slice_fmt_pkg::lane_mask_t simd_mask_i,
  input  slice_op_pkg::aux_t        aux_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic                      busy_o,
  lane_result_if.producer           result_if
);
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  logic [NUM_LANES-1:0] lane_in_ready, lane_busy;
  aux_t                 lane_aux [NUM_LANES];
  logic                 is_cpk, result_is_vector;

  assign is_cpk           = (op_i == CPKAB) || (op_i == CPKCD);
  assign result_is_vector = lane_aux[0][AUX_VEC_BIT];

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane
    lane_data_t a_local, b_local;
    logic       in_valid, out_valid, out_ready;

    always_comb begin : slice_operands
      a_local = lane_data_t'(operand_a_i >> (lane * fp_width(src_fmt_i)));
      b_local = lane_data_t'(operand_b_i >> (lane * fp_width(src_fmt_i)));
      if (is_cpk && (lane == 1)) begin
        a_local = lane_data_t'(operand_b_i); // Lane 1 packs the low element of B
      end
    end

    // Upper lanes follow lane 0 and only join in for vectors
    assign in_valid  = (lane == 0) ? in_valid_i :
                       (in_valid_i & vectorial_op_i & lane_in_ready[0]);
    assign out_ready = result_if.out_ready & ((lane == 0) | result_is_vector);
    assign result_if.lane_valid[lane] = out_valid & ((lane == 0) | result_is_vector);

    nc_lane nc_lane_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush_i),
      .a_i         (a_local),
      .b_i         (b_local),
      .op_i        (op_i),
      .fmt_i       (src_fmt_i),
      .mask_i      (simd_mask_i[lane]),
      .aux_i       ((lane == 0) ? aux_i : aux_t'('0)),
      .in_valid_i  (in_valid),
      .in_ready_o  (lane_in_ready[lane]),
      .result_o    (result_if.lane_result[lane]),
      .status_o    (result_if.lane_status[lane]),
      .mask_o      (result_if.lane_mask[lane]),
      .aux_o       (lane_aux[lane]),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready),
      .busy_o      (lane_busy[lane])
    );
  end

  assign result_if.aux = lane_aux[0];
  assign in_ready_o    = lane_in_ready[0]; // Upstream sees lane 0 only
  assign busy_o        = |lane_busy;

endmodule

/* nc_lane.sv */
`timescale 1ns/1ps

module nc_lane #(
  parameter int unsigned num_stages = slice_op_pkg::NUM_PIPE_REGS
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  input  slice_fmt_pkg::lane_data_t a_i,
  input  slice_fmt_pkg::lane_data_t b_i,
  input  slice_op_pkg::operation_e  op_i,
  input  slice_fmt_pkg::fp_format_e fmt_i,
  input  logic                     mask_i,
  input  slice_op_pkg::aux_t        aux_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output slice_fmt_pkg::lane_data_t result_o,
  output slice_op_pkg::status_t     status_o,
  output logic                     mask_o,
  output slice_op_pkg::aux_t        aux_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  logic [4:0] sign_pos, quiet_pos;
  lane_data_t mag_mask, man_mask, inf_pat, canon_nan;
  lane_data_t mag_a, mag_b, op_result;
  logic       sign_a, sign_b, nan_a, nan_b, snan_a, snan_b, a_lt_b;
  status_t    op_status;

  // ----------------------------------------------------------
  // Operation on one element
  // ----------------------------------------------------------
  always_comb begin : fmt_fields
    sign_pos  = 5'(fp_width(fmt_i) - 1);
    quiet_pos = 5'(man_bits(fmt_i) - 1);
    mag_mask  = (lane_data_t'(1) << sign_pos) - 1;
    man_mask  = (lane_data_t'(1) << man_bits(fmt_i)) - 1;
    inf_pat   = mag_mask & ~man_mask; // Exponent all ones
    canon_nan = inf_pat | (lane_data_t'(1) << quiet_pos);
  end

  assign sign_a = a_i[sign_pos];
  assign sign_b = b_i[sign_pos];
  assign mag_a  = a_i & mag_mask;
  assign mag_b  = b_i & mag_mask;
  assign nan_a  = ((mag_a & inf_pat) == inf_pat) && ((mag_a & man_mask) != '0);
  assign nan_b  = ((mag_b & inf_pat) == inf_pat) && ((mag_b & man_mask) != '0);
  assign snan_a = nan_a && !a_i[quiet_pos];
  assign snan_b = nan_b && !b_i[quiet_pos];

  // Sign decides first, so -0 orders below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b; // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : compute
    op_result = a_i; // CPK ops pass A through
    op_status = '0;
    case (op_i)
      SGNJ:  op_result[sign_pos] = sign_b;
      SGNJN: op_result[sign_pos] = ~sign_b;
      SGNJX: op_result[sign_pos] = sign_a ^ sign_b;
      MIN, MAX: begin
        op_status[STATUS_NV] = snan_a | snan_b;
        if (nan_a && nan_b) begin
          op_result = canon_nan;
        end else if (nan_a) begin
          op_result = b_i;
        end else if (nan_b) begin
          op_result = a_i;
        end else if ((op_i == MIN) == a_lt_b) begin
          op_result = a_i;
        end else begin
          op_result = b_i;
        end
      end
      default: op_result = a_i;
    endcase
  end

  // ----------------------------------------------------------
  // Handshaked pipeline, index i is the output of stage i
  // ----------------------------------------------------------
  lane_data_t res_q   [num_stages+1];
  status_t    status_q[num_stages+1];
  logic       mask_q  [num_stages+1];
  aux_t       aux_q   [num_stages+1];
  logic       valid_q [num_stages+1];
  logic [1:num_stages+1] ready; // Stage i can take an item

  assign res_q[0]    = op_result;
  assign status_q[0] = op_status;
  assign mask_q[0]   = mask_i;
  assign aux_q[0]    = aux_i;
  assign valid_q[0]  = in_valid_i;
  assign ready[num_stages+1] = out_ready_i;

  for (genvar i = 1; i <= num_stages; i++) begin : gen_stage
    assign ready[i] = ready[i+1] | ~valid_q[i]; // Empty or draining

    always_ff @(posedge clk_i) begin : stage_valid
      if (rst_i || flush_i) begin
        valid_q[i] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i] <= valid_q[i-1];
      end
    end

    always_ff @(posedge clk_i) begin : stage_data
      if (ready[i] && valid_q[i-1]) begin
        res_q[i]    <= res_q[i-1];
        status_q[i] <= status_q[i-1];
        mask_q[i]   <= mask_q[i-1];
        aux_q[i]    <= aux_q[i-1];
      end
    end
  end

  always_comb begin : busy_detect
    busy_o = 1'b0;
    for (int i = 1; i <= num_stages; i++) begin
      busy_o |= valid_q[i];
    end
  end

  assign in_ready_o  = ready[1];
  assign out_valid_o = valid_q[num_stages];
  assign result_o    = res_q[num_stages];
  assign status_o    = status_q[num_stages];
  assign mask_o      = mask_q[num_stages];
  assign aux_o       = aux_q[num_stages];

endmodule

/* lane_result_if.sv */
`timescale 1ns/1ps

interface lane_result_if;
  import slice_fmt_pkg::*;
  import slice_op_pkg::*;

  lane_data_t [NUM_LANES-1:0] lane_result;
  status_t    [NUM_LANES-1:0] lane_status;
  lane_mask_t                 lane_mask;  // SIMD mask as it left each lane
  lane_mask_t                 lane_valid; // Already gated for scalar results
  aux_t                       aux;        // From lane 0 only
  logic                       out_ready;

  modport producer (
    output lane_result, lane_status, lane_mask, lane_valid, aux,
    input  out_ready
  );

  modport consumer (
    input  lane_result, lane_status, lane_mask, lane_valid, aux,
    output out_ready
  );

endinterface

/* slice_op_pkg.sv */
package slice_op_pkg;

  localparam int unsigned NUM_PIPE_REGS = 2; // Register stages in lanes and bypass
  localparam int unsigned NUM_OPERANDS  = 3;
  localparam int unsigned NUM_CPK_SLOTS = 4; // Destination slots for cast-and-pack

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4,
    CPKAB = 3'd5,
    CPKCD = 3'd6
  } operation_e;

  // IEEE flags, ordered NV DZ OF UF NX from the top bit
  typedef logic [4:0] status_t;
  localparam int unsigned STATUS_NV = 4;

  // ----------------------------------------------------------
  // Side information travelling with lane 0
  // ----------------------------------------------------------
  typedef logic [2:0] aux_t;
  localparam int unsigned AUX_CPK_BIT = 2; // Result is a cast-and-pack
  localparam int unsigned AUX_VEC_BIT = 1; // Result is a vector
  localparam int unsigned AUX_FMT_BIT = 0; // Destination format

  typedef logic [1:0] vec_op_t; // Pack slot, {CPKCD, op_mod}

endpackage

/* slice_fmt_pkg.sv */
package slice_fmt_pkg;

  // ----------------------------------------------------------
  // Datapath geometry
  // ----------------------------------------------------------
  localparam int unsigned WIDTH       = 64; // Full operand/result word
  localparam int unsigned NUM_LANES   = 4;  // Enough lanes for the narrowest format
  localparam int unsigned LANE_WIDTH  = 32; // Widest element handled by a lane
  localparam int unsigned NUM_FORMATS = 2;

  // Encoding doubles as the index into per-format result arrays
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef logic [WIDTH-1:0]      data_t;
  typedef logic [LANE_WIDTH-1:0] lane_data_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t; // One bit per lane

  // Total element width of a format
  function automatic int unsigned fp_width(fp_format_e fmt);
    if (fmt == FP16) begin
      return 16;
    end
    return 32;
  endfunction

  // Stored mantissa bits, without the hidden one
  function automatic int unsigned man_bits(fp_format_e fmt);
    if (fmt == FP16) begin
      return 10;
    end
    return 23;
  endfunction

endpackage
